// ==== rtl/risc16_cfg.svh ====
// Word-addressed RiSC-16 sizes; instruction encodings assume a 16-bit word and 3-bit register fields
`ifndef RISC16_CFG_SVH
`define RISC16_CFG_SVH

// --------------------------------------------------
// Datapath
// --------------------------------------------------

// Data word and PC width, both memories are word addressed
`define RISC16_XLEN 16

// --------------------------------------------------
// Register file
// --------------------------------------------------

`define RISC16_REG_AW 3
`define RISC16_NUM_REGS 8

// First instruction fetched after reset
`define RISC16_RESET_PC 16'h0000

`endif

// ==== rtl/risc16_pkg.sv ====
// Types shared by the RiSC-16 pipeline; field order of inst_u follows the ISA bit layout
`include "risc16_cfg.svh"

package risc16_pkg;

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_ADDI = 3'd1,
        OP_NAND = 3'd2,
        OP_LUI  = 3'd3,
        OP_SW   = 3'd4,
        OP_LW   = 3'd5,
        OP_BEQ  = 3'd6,
        OP_JALR = 3'd7
    } opcode_e;

    // --------------------------------------------------
    // Instruction formats
    // --------------------------------------------------

    typedef struct packed {
        opcode_e                   opcode;
        logic [`RISC16_REG_AW-1:0] reg_a;
        logic [`RISC16_REG_AW-1:0] reg_b;
        logic [3:0]                pad;
        logic [`RISC16_REG_AW-1:0] reg_c;
    } inst_rrr_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`RISC16_REG_AW-1:0] reg_a;
        logic [`RISC16_REG_AW-1:0] reg_b;
        logic signed [6:0]         imm;
    } inst_rri_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`RISC16_REG_AW-1:0] reg_a;
        logic [9:0]                imm;
    } inst_ri_t;

    typedef union packed {
        inst_rrr_t rrr;
        inst_rri_t rri;
        inst_ri_t  ri;
    } inst_u;

    // --------------------------------------------------
    // Stage registers and control
    // --------------------------------------------------

    typedef struct packed {
        logic                    valid;
        logic [`RISC16_XLEN-1:0] pc;
        inst_u                   inst;
    } fetch_t;

    typedef struct packed {
        logic                      valid;
        logic [`RISC16_XLEN-1:0]   pc;
        opcode_e                   op;
        logic [`RISC16_REG_AW-1:0] tgt;
        logic [`RISC16_REG_AW-1:0] src1;
        logic [`RISC16_REG_AW-1:0] src2;
        logic [`RISC16_XLEN-1:0]   opnd1;
        logic [`RISC16_XLEN-1:0]   opnd2;
        logic [`RISC16_XLEN-1:0]   imm;
    } decode_t;

    typedef struct packed {
        logic                      valid;
        logic [`RISC16_XLEN-1:0]   pc;
        opcode_e                   op;
        logic [`RISC16_REG_AW-1:0] tgt;
        logic [`RISC16_XLEN-1:0]   result;
        logic [`RISC16_XLEN-1:0]   sw_data;
        logic                      eq;
        logic [`RISC16_XLEN-1:0]   imm;
    } exec_t;

    typedef struct packed {
        logic                      valid;
        logic [`RISC16_REG_AW-1:0] tgt;
        logic [`RISC16_XLEN-1:0]   data;
    } result_t;

    typedef struct packed {
        logic                    en;
        logic [`RISC16_XLEN-1:0] pc;
    } redirect_t;

    // Execute never holds, nothing after it stalls
    typedef struct packed {
        logic hold_fetch;
        logic bubble_fetch;
        logic hold_decode;
        logic bubble_decode;
        logic bubble_exec;
    } stall_t;

endpackage

// ==== rtl/risc16_hazard.sv ====
// Pure combinational stall logic; relies on bubbled stage registers carrying opcode ADD and zero regs
`include "risc16_cfg.svh"

module risc16_hazard import risc16_pkg::*; (
    input  fetch_t  i_fetch,
    input  decode_t i_decode,
    input  exec_t   i_exec,
    output stall_t  o_stall
);

    opcode_e fetch_op;
    logic    load_use;

    assign fetch_op = i_fetch.inst.rrr.opcode;

    // Load result arrives one stage too late for the instruction behind it
    assign load_use = i_exec.valid && (i_exec.op == OP_LW)
                   && (i_exec.tgt != '0)
                   && ((i_exec.tgt == i_decode.src1) || (i_exec.tgt == i_decode.src2));

    always_comb begin
        o_stall.bubble_exec   = load_use;
        // BEQ resolves one stage later than JALR, so decode also bubbles
        o_stall.bubble_decode = i_decode.valid && (i_decode.op == OP_BEQ);
        o_stall.bubble_fetch  = i_fetch.valid
                             && ((fetch_op == OP_BEQ) || (fetch_op == OP_JALR));

        // Every earlier stage holds while a later one bubbles
        o_stall.hold_decode   = o_stall.bubble_exec;
        o_stall.hold_fetch    = o_stall.bubble_decode || o_stall.hold_decode;
    end

endmodule

// ==== rtl/risc16_fetch.sv ====
// Fetch expects combinational instruction memory; a redirect overrides the sequential PC same cycle
`include "risc16_cfg.svh"

module risc16_fetch import risc16_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic [`RISC16_XLEN-1:0] i_inst,
    input  redirect_t               i_redirect,
    input  stall_t                  i_stall,
    output logic [`RISC16_XLEN-1:0] o_pc_next,
    output fetch_t                  o_fetch
);

    logic [`RISC16_XLEN-1:0] pc_seq;
    fetch_t                  fetch_q;

    // --------------------------------------------------
    // Next PC
    // --------------------------------------------------

    assign o_pc_next = i_redirect.en ? i_redirect.pc : pc_seq;

    // PC stops while fetch holds or waits on a control instruction
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc_seq <= `RISC16_RESET_PC;
        end else if (!i_stall.hold_fetch && !i_stall.bubble_fetch) begin
            pc_seq <= o_pc_next + 1'b1;
        end
    end

    // --------------------------------------------------
    // Fetch register
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            fetch_q <= '0;
        end else if (i_stall.hold_fetch) begin
            fetch_q <= fetch_q;
        end else if (i_stall.bubble_fetch) begin
            // Zero word decodes as ADD r0, so the bubble carries no sources
            fetch_q.valid <= 1'b0;
            fetch_q.inst  <= '0;
        end else begin
            fetch_q.valid <= 1'b1;
            fetch_q.pc    <= o_pc_next;
            fetch_q.inst  <= i_inst;
        end
    end

    assign o_fetch = fetch_q;

endmodule

// ==== rtl/risc16_regfile.sv ====
// Register file without internal write-through; readers in the same cycle see the old value
`include "risc16_cfg.svh"

module risc16_regfile import risc16_pkg::*; (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic [`RISC16_REG_AW-1:0] i_rd_addr1,
    input  logic [`RISC16_REG_AW-1:0] i_rd_addr2,
    output logic [`RISC16_XLEN-1:0]   o_rd_data1,
    output logic [`RISC16_XLEN-1:0]   o_rd_data2,
    input  result_t                   i_wr
);

    logic [`RISC16_XLEN-1:0] regs [`RISC16_NUM_REGS];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `RISC16_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr.valid && (i_wr.tgt != '0)) begin
            regs[i_wr.tgt] <= i_wr.data;
        end
    end

    // r0 is hard-wired to zero
    assign o_rd_data1 = (i_rd_addr1 == '0) ? '0 : regs[i_rd_addr1];
    assign o_rd_data2 = (i_rd_addr2 == '0) ? '0 : regs[i_rd_addr2];

endmodule

// ==== rtl/risc16_decode.sv ====
// Decode; operands bypass the write port so a held instruction never keeps a stale register value
`include "risc16_cfg.svh"

module risc16_decode import risc16_pkg::*; (
    input  logic    i_clk,
    input  logic    i_rst,
    input  fetch_t  i_fetch,
    input  stall_t  i_stall,
    input  result_t i_wr,
    output decode_t o_decode
);

    inst_u                     inst;
    opcode_e                   op;
    logic [`RISC16_XLEN-1:0]   simm_ext;
    logic [`RISC16_XLEN-1:0]   limm_ext;
    logic [`RISC16_XLEN-1:0]   rd_data1;
    logic [`RISC16_XLEN-1:0]   rd_data2;
    decode_t                   dec_d;
    decode_t                   dec_q;

    // Value being written this cycle wins over the register file copy
    function automatic logic [`RISC16_XLEN-1:0] wr_bypass(
        input logic [`RISC16_REG_AW-1:0] src,
        input logic [`RISC16_XLEN-1:0]   rd_val,
        input result_t                   wr
    );
        logic hit;
        hit = wr.valid && (wr.tgt != '0) && (wr.tgt == src);
        return hit ? wr.data : rd_val;
    endfunction

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------

    assign inst     = i_fetch.inst;
    assign op       = inst.rrr.opcode;
    assign simm_ext = {{(`RISC16_XLEN-7){inst.rri.imm[6]}}, inst.rri.imm};
    assign limm_ext = {inst.ri.imm, {(`RISC16_XLEN-10){1'b0}}};

    always_comb begin
        dec_d       = '0;
        dec_d.valid = i_fetch.valid;
        dec_d.pc    = i_fetch.pc;
        dec_d.op    = op;
        case (op)
            OP_ADD, OP_NAND: begin
                dec_d.tgt  = inst.rrr.reg_a;
                dec_d.src1 = inst.rrr.reg_b;
                dec_d.src2 = inst.rrr.reg_c;
            end
            OP_ADDI, OP_LW: begin
                dec_d.tgt  = inst.rri.reg_a;
                dec_d.src1 = inst.rri.reg_b;
                dec_d.imm  = simm_ext;
            end
            OP_LUI: begin
                dec_d.tgt  = inst.ri.reg_a;
                dec_d.imm  = limm_ext;
            end
            // Stores and branches read reg a as the second operand
            OP_SW, OP_BEQ: begin
                dec_d.src1 = inst.rri.reg_b;
                dec_d.src2 = inst.rri.reg_a;
                dec_d.imm  = simm_ext;
            end
            default: begin
                dec_d.tgt  = inst.rri.reg_a;
                dec_d.src1 = inst.rri.reg_b;
            end
        endcase
        dec_d.opnd1 = wr_bypass(dec_d.src1, rd_data1, i_wr);
        dec_d.opnd2 = wr_bypass(dec_d.src2, rd_data2, i_wr);
    end

    risc16_regfile u_regfile (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rd_addr1 (dec_d.src1),
        .i_rd_addr2 (dec_d.src2),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2),
        .i_wr       (i_wr)
    );

    // --------------------------------------------------
    // Decode register
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            dec_q <= '0;
        end else if (i_stall.hold_decode) begin
            dec_q.opnd1 <= wr_bypass(dec_q.src1, dec_q.opnd1, i_wr);
            dec_q.opnd2 <= wr_bypass(dec_q.src2, dec_q.opnd2, i_wr);
        end else if (i_stall.bubble_decode) begin
            dec_q <= '0;
        end else begin
            dec_q <= dec_d;
        end
    end

    assign o_decode = dec_q;

endmodule

// ==== rtl/risc16_execute.sv ====
// Execute; BEQ redirects from its own register, JALR from decode, both only for valid entries
`include "risc16_cfg.svh"

module risc16_execute import risc16_pkg::*; (
    input  logic      i_clk,
    input  logic      i_rst,
    input  decode_t   i_decode,
    input  stall_t    i_stall,
    input  result_t   i_mem_res,
    input  result_t   i_wb_res,
    output exec_t     o_exec,
    output redirect_t o_redirect
);

    exec_t                   exec_q;
    result_t                 exec_res;
    logic [`RISC16_XLEN-1:0] fwd1;
    logic [`RISC16_XLEN-1:0] fwd2;
    logic [`RISC16_XLEN-1:0] pc_inc;
    logic [`RISC16_XLEN-1:0] alu_a;
    logic [`RISC16_XLEN-1:0] alu_b;
    logic [`RISC16_XLEN-1:0] alu_out;
    logic                    use_rrr;

    // Youngest producer wins: execute, then memory, then writeback
    function automatic logic [`RISC16_XLEN-1:0] fwd_operand(
        input logic [`RISC16_REG_AW-1:0] src,
        input logic [`RISC16_XLEN-1:0]   rd_val,
        input result_t                   ex,
        input result_t                   mem,
        input result_t                   wb
    );
        logic [`RISC16_XLEN-1:0] val;
        val = rd_val;
        if (wb.valid && (wb.tgt == src)) val = wb.data;
        if (mem.valid && (mem.tgt == src)) val = mem.data;
        if (ex.valid && (ex.tgt == src)) val = ex.data;
        if (src == '0) val = '0;
        return val;
    endfunction

    // --------------------------------------------------
    // Forwarding and ALU
    // --------------------------------------------------

    assign exec_res.valid = exec_q.valid;
    assign exec_res.tgt   = exec_q.tgt;
    assign exec_res.data  = exec_q.result;

    assign fwd1 = fwd_operand(i_decode.src1, i_decode.opnd1, exec_res, i_mem_res, i_wb_res);
    assign fwd2 = fwd_operand(i_decode.src2, i_decode.opnd2, exec_res, i_mem_res, i_wb_res);

    assign pc_inc  = i_decode.pc + 1'b1;
    assign use_rrr = (i_decode.op == OP_ADD) || (i_decode.op == OP_NAND)
                  || (i_decode.op == OP_BEQ);

    // JALR links PC+1; its immediate is zero
    assign alu_a   = (i_decode.op == OP_JALR) ? pc_inc : fwd1;
    assign alu_b   = use_rrr ? fwd2 : i_decode.imm;
    assign alu_out = (i_decode.op == OP_NAND) ? ~(alu_a & alu_b) : (alu_a + alu_b);

    // --------------------------------------------------
    // Execute register
    // --------------------------------------------------

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            exec_q <= '0;
        end else if (i_stall.bubble_exec) begin
            exec_q <= '0;
        end else begin
            exec_q.valid   <= i_decode.valid;
            exec_q.pc      <= i_decode.pc;
            exec_q.op      <= i_decode.op;
            exec_q.tgt     <= i_decode.tgt;
            exec_q.result  <= alu_out;
            exec_q.sw_data <= fwd2;
            exec_q.eq      <= (fwd1 == fwd2);
            exec_q.imm     <= i_decode.imm;
        end
    end

    // Redirect
    always_comb begin
        o_redirect.en = 1'b0;
        o_redirect.pc = exec_q.pc + 1'b1;
        if (exec_q.valid && (exec_q.op == OP_BEQ)) begin
            o_redirect.en = 1'b1;
            if (exec_q.eq) begin
                o_redirect.pc = exec_q.pc + 1'b1 + exec_q.imm;
            end
        end else if (i_decode.valid && (i_decode.op == OP_JALR)) begin
            o_redirect.en = 1'b1;
            o_redirect.pc = fwd1;
        end
    end

    assign o_exec = exec_q;

endmodule

// ==== rtl/risc16_mem_wb.sv ====
// Memory and writeback; data memory must return load data exactly one cycle after the address
`include "risc16_cfg.svh"

module risc16_mem_wb import risc16_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  exec_t                   i_exec,
    input  logic [`RISC16_XLEN-1:0] i_mem_rd_data,
    output logic [`RISC16_XLEN-1:0] o_mem_addr,
    output logic [`RISC16_XLEN-1:0] o_mem_wr_data,
    output logic                    o_mem_wr_en,
    output result_t                 o_mem_res,
    output result_t                 o_wb_res
);

    result_t mem_q;
    logic    mem_is_load;
    result_t wb_q;

    // Memory port straight from the execute register
    assign o_mem_addr    = i_exec.result;
    assign o_mem_wr_data = i_exec.sw_data;
    assign o_mem_wr_en   = i_exec.valid && (i_exec.op == OP_SW);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            mem_q       <= '0;
            mem_is_load <= 1'b0;
            wb_q        <= '0;
        end else begin
            mem_q.valid <= i_exec.valid;
            mem_q.tgt   <= i_exec.tgt;
            mem_q.data  <= i_exec.result;
            mem_is_load <= i_exec.valid && (i_exec.op == OP_LW);
            wb_q        <= o_mem_res;
        end
    end

    // Load data lands here, in time for the register file write
    assign o_mem_res.valid = mem_q.valid;
    assign o_mem_res.tgt   = mem_q.tgt;
    assign o_mem_res.data  = mem_is_load ? i_mem_rd_data : mem_q.data;

    assign o_wb_res = wb_q;

endmodule

// ==== rtl/risc16_core.sv ====
// RiSC-16 five-stage core; instruction memory combinational, data memory one-cycle read latency
`include "risc16_cfg.svh"

module risc16_core import risc16_pkg::*; (
    input  logic                    i_clk,
    input  logic                    i_rst,
    input  logic [`RISC16_XLEN-1:0] i_inst,
    output logic [`RISC16_XLEN-1:0] o_pc_next,
    input  logic [`RISC16_XLEN-1:0] i_mem_rd_data,
    output logic [`RISC16_XLEN-1:0] o_mem_wr_data,
    output logic [`RISC16_XLEN-1:0] o_mem_addr,
    output logic                    o_mem_wr_en
);

    fetch_t    fetch_s;
    decode_t   decode_s;
    exec_t     exec_s;
    redirect_t redirect;
    stall_t    stall;
    result_t   mem_res;
    result_t   wb_res;

    risc16_hazard u_hazard (
        .i_fetch  (fetch_s),
        .i_decode (decode_s),
        .i_exec   (exec_s),
        .o_stall  (stall)
    );

    risc16_fetch u_fetch (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_inst     (i_inst),
        .i_redirect (redirect),
        .i_stall    (stall),
        .o_pc_next  (o_pc_next),
        .o_fetch    (fetch_s)
    );

    // Register file writes from the memory stage
    risc16_decode u_decode (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_fetch  (fetch_s),
        .i_stall  (stall),
        .i_wr     (mem_res),
        .o_decode (decode_s)
    );

    risc16_execute u_execute (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_decode   (decode_s),
        .i_stall    (stall),
        .i_mem_res  (mem_res),
        .i_wb_res   (wb_res),
        .o_exec     (exec_s),
        .o_redirect (redirect)
    );

    risc16_mem_wb u_mem_wb (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_exec        (exec_s),
        .i_mem_rd_data (i_mem_rd_data),
        .o_mem_addr    (o_mem_addr),
        .o_mem_wr_data (o_mem_wr_data),
        .o_mem_wr_en   (o_mem_wr_en),
        .o_mem_res     (mem_res),
        .o_wb_res      (wb_res)
    );

endmodule

// ==== verification/risc16_checker.sv ====
// Reset, hazard and r0 checks bound into the core; data values are left to the store comparison
`include "risc16_cfg.svh"

module risc16_checker import risc16_pkg::*; (
    input logic                    i_clk,
    input logic                    i_rst,
    input fetch_t                  i_fetch,
    input decode_t                 i_decode,
    input exec_t                   i_exec,
    input stall_t                  i_stall,
    input logic                    i_mem_wr_en,
    input logic [`RISC16_XLEN-1:0] i_pc_next
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;
    logic        fetch_beq;
    logic        fetch_ctrl;
    logic        load_use;

    // Control instruction leaving fetch this cycle
    assign fetch_beq  = i_fetch.valid && !i_stall.hold_fetch
                     && (i_fetch.inst.rrr.opcode == OP_BEQ);
    assign fetch_ctrl = fetch_beq || (i_fetch.valid && !i_stall.hold_fetch
                     && (i_fetch.inst.rrr.opcode == OP_JALR));

    assign load_use = i_exec.valid && (i_exec.op == OP_LW) && (i_exec.tgt != '0)
                   && ((i_exec.tgt == i_decode.src1) || (i_exec.tgt == i_decode.src2));

    // --------------------------------------------------
    // Assertions
    // --------------------------------------------------

    // Reset empties every stage and restarts fetch at the reset PC
    assert property (@(posedge i_clk) i_rst |=> !i_mem_wr_en && !i_fetch.valid
                                            && !i_decode.valid && !i_exec.valid
                                            && (i_pc_next == `RISC16_RESET_PC))
        else begin
            fail_count++;
            $error("pipeline not cleared or PC not at reset value after reset");
        end

    // BEQ and JALR both leave one bubble behind them
    assert property (@(posedge i_clk) disable iff (i_rst) fetch_ctrl |=> !i_fetch.valid)
        else begin
            fail_count++;
            $error("no fetch bubble after a control instruction");
        end

    assert property (@(posedge i_clk) disable iff (i_rst) fetch_beq |-> ##2 !i_fetch.valid)
        else begin
            fail_count++;
            $error("no second fetch bubble after BEQ");
        end

    // Exactly one execute bubble, then the dependent instruction moves on
    assert property (@(posedge i_clk) disable iff (i_rst)
        load_use |=> !i_exec.valid ##1 i_exec.valid)
        else begin
            fail_count++;
            $error("load-use interlock did not insert exactly one bubble");
        end

    // Register zero reads as zero even right after an instruction targets it
    assert property (@(posedge i_clk) disable iff (i_rst)
        i_decode.valid |-> ((i_decode.src1 != '0) || (i_decode.opnd1 == '0))
                        && ((i_decode.src2 != '0) || (i_decode.opnd2 == '0)))
        else begin
            fail_count++;
            $error("register zero read back a nonzero value");
        end

endmodule

bind risc16_core risc16_checker u_checker (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_fetch     (fetch_s),
    .i_decode    (decode_s),
    .i_exec      (exec_s),
    .i_stall     (stall),
    .i_mem_wr_en (o_mem_wr_en),
    .i_pc_next   (o_pc_next)
);

// ==== verification/risc16_tb.sv ====
// Program must fit the 64-word instruction array and keep all store slots below address 64
`include "risc16_cfg.svh"

module risc16_tb import risc16_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [2:0]              test;
        logic [`RISC16_XLEN-1:0] addr;
        logic [`RISC16_XLEN-1:0] data;
    } store_t;

    logic                    clk = 1'b0;
    logic                    rst = 1'b1;
    logic [`RISC16_XLEN-1:0] inst;
    logic [`RISC16_XLEN-1:0] pc_next;
    logic [`RISC16_XLEN-1:0] mem_rd_data = '0;
    logic [`RISC16_XLEN-1:0] mem_wr_data;
    logic [`RISC16_XLEN-1:0] mem_addr;
    logic                    mem_wr_en;

    logic [`RISC16_XLEN-1:0] imem [64];
    logic [`RISC16_XLEN-1:0] dmem [256];
    logic [`RISC16_XLEN-1:0] mdl_mem [256];
    logic [2:0]              test_of [64];
    store_t                  store_q [$];
    store_t                  exp_head = '0;
    logic                    exp_valid = 1'b0;
    logic [31:0]             lfsr = 32'h6a1d0e21;
    int                      pc_asm = 0;
    int                      cur_test = 0;
    int                      slot = 8;
    int                      prog_len = 0;
    string                   test_names [6] = '{"alu", "forward", "load_use", "branch",
                                                "jalr", "reg_zero"};

    risc16_core uut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_inst        (inst),
        .o_pc_next     (pc_next),
        .i_mem_rd_data (mem_rd_data),
        .o_mem_wr_data (mem_wr_data),
        .o_mem_addr    (mem_addr),
        .o_mem_wr_en   (mem_wr_en)
    );

    always #2 clk = ~clk;

    // --------------------------------------------------
    // Memory models
    // --------------------------------------------------

    assign inst = imem[pc_next[5:0]];

    // Write lands on the edge, read data follows one cycle after the address
    always @(posedge clk) begin : data_mem
        logic [`RISC16_XLEN-1:0] a;
        logic [`RISC16_XLEN-1:0] d;
        logic                    we;
        a  = mem_addr;
        d  = mem_wr_data;
        we = mem_wr_en;
        #1;
        if (we) dmem[a[7:0]] = d;
        mem_rd_data = dmem[a[7:0]];
    end

    // --------------------------------------------------
    // Program generation
    // --------------------------------------------------

    function automatic logic [15:0] rand_bits(input int nbits);
        logic [15:0] v;
        logic        b;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 32'hd000_0001;
            v = {v[14:0], b};
        end
        return v;
    endfunction

    // Distinct nonzero registers for k = 0..6
    function automatic int pick_reg(input int base, input int k);
        return ((base + k) % 7) + 1;
    endfunction

    task automatic emit(input opcode_e op, input int ra, input int rb, input int fld);
        logic [15:0] w;
        case (op)
            OP_ADD, OP_NAND: w = {op, 3'(ra), 3'(rb), 4'b0000, 3'(fld)};
            OP_LUI:          w = {op, 3'(ra), 10'(fld)};
            default:         w = {op, 3'(ra), 3'(rb), 7'(fld)};
        endcase
        imem[pc_asm]    = w;
        test_of[pc_asm] = 3'(cur_test);
        pc_asm++;
    endtask

    task automatic store_reg(input int r);
        emit(OP_SW, r, 0, slot);
        slot++;
    endtask

    task automatic build_program();
        int base;
        int s;
        for (int i = 0; i < 64; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i]    = {8'(i), ~8'(i)} ^ 16'h1d2b;
            mdl_mem[i] = {8'(i), ~8'(i)} ^ 16'h1d2b;
        end
        // Every ALU path and both immediate forms
        cur_test = 0;
        base = rand_bits(3);
        emit(OP_LUI, pick_reg(base, 0), 0, rand_bits(10));
        emit(OP_ADDI, pick_reg(base, 0), pick_reg(base, 0), rand_bits(7));
        emit(OP_ADDI, pick_reg(base, 1), 0, rand_bits(7));
        emit(OP_ADD, pick_reg(base, 2), pick_reg(base, 0), pick_reg(base, 1));
        emit(OP_NAND, pick_reg(base, 3), pick_reg(base, 2), pick_reg(base, 0));
        store_reg(pick_reg(base, 2));
        store_reg(pick_reg(base, 3));
        store_reg(pick_reg(base, 0));
        // Producers at distance one, two and three
        cur_test = 1;
        base = rand_bits(3);
        emit(OP_ADDI, pick_reg(base, 0), 0, rand_bits(7));
        emit(OP_ADDI, pick_reg(base, 1), 0, rand_bits(7));
        emit(OP_ADDI, pick_reg(base, 2), 0, rand_bits(7));
        emit(OP_ADD, pick_reg(base, 3), pick_reg(base, 0), pick_reg(base, 1));
        emit(OP_NAND, pick_reg(base, 4), pick_reg(base, 3), pick_reg(base, 2));
        store_reg(pick_reg(base, 4));
        store_reg(pick_reg(base, 3));
        // Store then reload, then a dependent use right behind each load
        cur_test = 2;
        base = rand_bits(3);
        s = slot;
        emit(OP_ADDI, pick_reg(base, 0), 0, rand_bits(7));
        store_reg(pick_reg(base, 0));
        emit(OP_LW, pick_reg(base, 1), 0, s);
        emit(OP_ADDI, pick_reg(base, 2), pick_reg(base, 1), rand_bits(7));
        store_reg(pick_reg(base, 2));
        emit(OP_LW, pick_reg(base, 3), 0, rand_bits(6));
        emit(OP_ADD, pick_reg(base, 4), pick_reg(base, 3), pick_reg(base, 3));
        store_reg(pick_reg(base, 4));
        // Taken BEQ skips a store, untaken BEQ falls through
        cur_test = 3;
        base = rand_bits(3);
        emit(OP_ADDI, pick_reg(base, 0), 0, rand_bits(6) | 1);
        emit(OP_ADDI, pick_reg(base, 1), pick_reg(base, 0), 0);
        emit(OP_BEQ, pick_reg(base, 0), pick_reg(base, 1), 1);
        store_reg(pick_reg(base, 0));
        emit(OP_BEQ, pick_reg(base, 0), 0, 1);
        store_reg(pick_reg(base, 1));
        // JALR over one store, link register stored at the target
        cur_test = 4;
        base = rand_bits(3);
        emit(OP_ADDI, pick_reg(base, 0), 0, pc_asm + 3);
        emit(OP_JALR, pick_reg(base, 1), pick_reg(base, 0), 0);
        store_reg(pick_reg(base, 0));
        store_reg(pick_reg(base, 1));
        // r0 written by ALU and load, must still read zero
        cur_test = 5;
        base = rand_bits(3);
        emit(OP_ADDI, 0, 0, rand_bits(6) | 1);
        emit(OP_LW, 0, 0, rand_bits(6));
        emit(OP_ADD, pick_reg(base, 0), 0, 0);
        store_reg(0);
        store_reg(pick_reg(base, 0));
        // Self-branch ends the program
        emit(OP_BEQ, 0, 0, -1);
    endtask

    // --------------------------------------------------
    // Instruction-set model
    // --------------------------------------------------

    task automatic run_model();
        logic [15:0] r [8];
        logic [15:0] pc;
        logic [15:0] w;
        logic [15:0] va;
        logic [15:0] vb;
        logic [15:0] simm;
        logic [15:0] addr;
        logic [15:0] nxt;
        opcode_e     op;
        store_t      st;
        int          steps;
        for (int i = 0; i < 8; i++) begin
            r[i] = '0;
        end
        pc    = '0;
        steps = 0;
        while (steps < 1000) begin
            w    = imem[pc[5:0]];
            op   = opcode_e'(w[15:13]);
            va   = r[w[12:10]];
            vb   = r[w[9:7]];
            simm = {{9{w[6]}}, w[6:0]};
            addr = vb + simm;
            nxt  = pc + 16'd1;
            case (op)
                OP_ADD:  r[w[12:10]] = vb + r[w[2:0]];
                OP_ADDI: r[w[12:10]] = vb + simm;
                OP_NAND: r[w[12:10]] = ~(vb & r[w[2:0]]);
                OP_LUI:  r[w[12:10]] = {w[9:0], 6'b000000};
                OP_LW:   r[w[12:10]] = mdl_mem[addr[7:0]];
                OP_SW: begin
                    mdl_mem[addr[7:0]] = va;
                    st.test = test_of[pc[5:0]];
                    st.addr = addr;
                    st.data = va;
                    store_q.push_back(st);
                end
                OP_BEQ: begin
                    if (va == vb) nxt = pc + 16'd1 + simm;
                end
                default: begin
                    r[w[12:10]] = pc + 16'd1;
                    nxt = vb;
                end
            endcase
            r[0] = '0;
            steps++;
            if (nxt == pc) break;
            pc = nxt;
        end
    endtask

    // --------------------------------------------------
    // Store comparison
    // --------------------------------------------------

    task automatic refresh_head();
        exp_valid = (store_q.size() != 0);
        if (exp_valid) exp_head = store_q[0];
    endtask

    always @(posedge clk) begin
        if (!rst && mem_wr_en && (store_q.size() != 0)) begin
            void'(store_q.pop_front());
        end
        refresh_head();
    end

    assert property (@(posedge clk) disable iff (rst) mem_wr_en |-> exp_valid)
        else begin
            $display("store to address %h with no store left in the model", $sampled(mem_addr));
            $display("SIMULATION FAILED");
            $fatal(1, "unexpected store");
        end

    assert property (@(posedge clk) disable iff (rst)
        (mem_wr_en && exp_valid) |-> (mem_addr == exp_head.addr)
                                  && (mem_wr_data == exp_head.data))
        else begin
            $display("mismatch test %s expected addr %h data %h actual addr %h data %h",
                     test_names[$sampled(exp_head.test)], $sampled(exp_head.addr),
                     $sampled(exp_head.data), $sampled(mem_addr), $sampled(mem_wr_data));
            $display("SIMULATION FAILED");
            $fatal(1, "store mismatch");
        end

    initial begin : checker_watch
        wait (uut.u_checker.fail_count != 0);
        $display("pipeline hazard assertion failed in the bound checker");
        $display("SIMULATION FAILED");
        $fatal(1, "hazard check");
    end

    // Twenty cycles per instruction plus the reset cycles
    initial begin : watchdog
        wait (prog_len != 0);
        repeat (20 * prog_len + 5) @(posedge clk);
        $display("timeout with %0d stores still outstanding", store_q.size());
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        build_program();
        run_model();
        refresh_head();
        prog_len = pc_asm;
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        while (store_q.size() != 0) begin
            @(posedge clk);
        end
        // Halt loop keeps running so a stray store would still be caught
        repeat (20) @(posedge clk);
        if ((store_q.size() == 0) && (uut.u_checker.fail_count == 0)) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "end of run");
        end
    end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/risc16_pkg.sv
rtl/risc16_hazard.sv
rtl/risc16_fetch.sv
rtl/risc16_regfile.sv
rtl/risc16_decode.sv
rtl/risc16_execute.sv
rtl/risc16_mem_wb.sv
rtl/risc16_core.sv
verification/risc16_checker.sv
verification/risc16_tb.sv
